//--- bp_cfg_pkg.sv
package bp_cfg_pkg;

	// ********************
	// branch pc
	// ********************
	localparam int PC_WIDTH = 32;
	// table index bits start above the instruction byte offset
	localparam int PC_IDX_LSB = 2;

	// ********************
	// global predictor
	// ********************
	// history length doubles as gshare index width
	localparam int GHR_WIDTH = 8;
	localparam int GPT_ENTRIES = 1 << GHR_WIDTH;

	// ********************
	// local predictor
	// ********************
	localparam int LHT_IDX_WIDTH = 4;
	localparam int LHT_ENTRIES = 1 << LHT_IDX_WIDTH;
	localparam int LHIST_WIDTH = 4;
	localparam int LPT_ENTRIES = 1 << LHIST_WIDTH;

	// chooser table
	localparam int CHOICE_IDX_WIDTH = 6;
	localparam int CHOICE_ENTRIES = 1 << CHOICE_IDX_WIDTH;

endpackage

//--- bp_types_pkg.sv
package bp_types_pkg;

	// 2-bit saturating counter where the upper bit means taken
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} ctr_state_e;

	// chooser state where the upper bit means use global
	typedef enum logic [1:0] {
		strong_local  = 2'b00,
		weak_local    = 2'b01,
		weak_global   = 2'b10,
		strong_global = 2'b11
	} choice_e;

	// saturating step toward taken or not taken
	function automatic ctr_state_e ctr_update(input ctr_state_e cur, input logic taken);
		ctr_state_e nxt;
		nxt = cur;
		case (cur)
			strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
			weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
			strong_taken:     nxt = taken ? strong_taken : weak_taken;
			default:          nxt = weak_not_taken;
		endcase
		return nxt;
	endfunction

	// saturating step toward global or local
	function automatic choice_e choice_update(input choice_e cur, input logic to_global);
		choice_e nxt;
		nxt = cur;
		case (cur)
			strong_local:  nxt = to_global ? weak_local : strong_local;
			weak_local:    nxt = to_global ? weak_global : strong_local;
			weak_global:   nxt = to_global ? strong_global : weak_local;
			strong_global: nxt = to_global ? strong_global : weak_global;
			default:       nxt = weak_local;
		endcase
		return nxt;
	endfunction

endpackage

//--- local_predictor.sv
`timescale 1ns/100ps

module local_predictor (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   req_pc_i,
	input  logic                              train_valid_i,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   train_pc_i,
	input  logic                              train_taken_i,
	output logic                              local_pred_o
);

	// ********************
	// tables
	// ********************
	// per-branch history selected by pc
	logic [bp_cfg_pkg::LHIST_WIDTH-1:0] lht [bp_cfg_pkg::LHT_ENTRIES];
	// pattern counters selected by history
	bp_types_pkg::ctr_state_e lpt [bp_cfg_pkg::LPT_ENTRIES];

	logic [bp_cfg_pkg::LHT_IDX_WIDTH-1:0] req_idx;
	logic [bp_cfg_pkg::LHT_IDX_WIDTH-1:0] train_idx;
	logic [bp_cfg_pkg::LHIST_WIDTH-1:0]   req_hist;
	logic [bp_cfg_pkg::LHIST_WIDTH-1:0]   train_hist;
	bp_types_pkg::ctr_state_e             req_ctr;

	assign req_idx   = req_pc_i[bp_cfg_pkg::PC_IDX_LSB +: bp_cfg_pkg::LHT_IDX_WIDTH];
	assign train_idx = train_pc_i[bp_cfg_pkg::PC_IDX_LSB +: bp_cfg_pkg::LHT_IDX_WIDTH];

	// ********************
	// lookup
	// ********************
	// two level read of history then counter
	assign req_hist = lht[req_idx];
	assign req_ctr  = lpt[req_hist];

	assign local_pred_o = (req_ctr == bp_types_pkg::weak_taken) ||
	                      (req_ctr == bp_types_pkg::strong_taken);

	// ********************
	// training
	// ********************
	// counter indexed by the history before this outcome
	assign train_hist = lht[train_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < bp_cfg_pkg::LHT_ENTRIES; i++) begin
				lht[i] <= '0;
			end
			for (int j = 0; j < bp_cfg_pkg::LPT_ENTRIES; j++) begin
				lpt[j] <= bp_types_pkg::weak_not_taken;
			end
		end else if (train_valid_i) begin
			lpt[train_hist] <= bp_types_pkg::ctr_update(lpt[train_hist], train_taken_i);
			// newest outcome enters at bit 0
			lht[train_idx] <= {train_hist[bp_cfg_pkg::LHIST_WIDTH-2:0], train_taken_i};
		end
	end

endmodule

//--- global_predictor.sv
`timescale 1ns/100ps

module global_predictor (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   req_pc_i,
	input  logic                              train_valid_i,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   train_pc_i,
	input  logic                              train_taken_i,
	input  logic [bp_cfg_pkg::GHR_WIDTH-1:0]  train_ghr_i,
	output logic                              global_pred_o,
	output logic [bp_cfg_pkg::GHR_WIDTH-1:0]  ghr_o
);

	logic [bp_cfg_pkg::GHR_WIDTH-1:0] ghr;
	// gshare counters
	bp_types_pkg::ctr_state_e gpt [bp_cfg_pkg::GPT_ENTRIES];

	logic [bp_cfg_pkg::GHR_WIDTH-1:0] req_idx;
	logic [bp_cfg_pkg::GHR_WIDTH-1:0] train_idx;
	bp_types_pkg::ctr_state_e         req_ctr;

	// ********************
	// lookup
	// ********************
	// history xor the low pc bits
	assign req_idx = ghr ^ req_pc_i[bp_cfg_pkg::GHR_WIDTH-1:0];
	assign req_ctr = gpt[req_idx];

	assign global_pred_o = (req_ctr == bp_types_pkg::weak_taken) ||
	                       (req_ctr == bp_types_pkg::strong_taken);
	assign ghr_o = ghr;

	// ********************
	// training
	// ********************
	// returned history so lookup and training hit one entry
	assign train_idx = train_ghr_i ^ train_pc_i[bp_cfg_pkg::GHR_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			ghr <= '0;
			for (int i = 0; i < bp_cfg_pkg::GPT_ENTRIES; i++) begin
				gpt[i] <= bp_types_pkg::weak_not_taken;
			end
		end else if (train_valid_i) begin
			gpt[train_idx] <= bp_types_pkg::ctr_update(gpt[train_idx], train_taken_i);
			// rebuilt from the branch's own history
			ghr <= {train_ghr_i[bp_cfg_pkg::GHR_WIDTH-2:0], train_taken_i};
		end
	end

endmodule

//--- tournament_chooser.sv
`timescale 1ns/100ps

module tournament_chooser (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              req_valid_i,
	output logic                              req_ready_o,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   req_pc_i,
	input  logic                              local_pred_i,
	input  logic                              global_pred_i,
	input  logic [bp_cfg_pkg::GHR_WIDTH-1:0]  ghr_i,
	output logic                              res_valid_o,
	input  logic                              res_ready_i,
	output logic                              res_taken_o,
	output logic                              res_local_o,
	output logic                              res_global_o,
	output logic [bp_cfg_pkg::GHR_WIDTH-1:0]  res_ghr_o,
	input  logic                              train_valid_i,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   train_pc_i,
	input  logic                              train_taken_i,
	input  logic                              train_local_i,
	input  logic                              train_global_i
);

	bp_types_pkg::choice_e cht [bp_cfg_pkg::CHOICE_ENTRIES];

	logic [bp_cfg_pkg::CHOICE_IDX_WIDTH-1:0] req_idx;
	logic [bp_cfg_pkg::CHOICE_IDX_WIDTH-1:0] train_idx;
	bp_types_pkg::choice_e                   req_choice;
	logic                                    use_global;
	logic                                    req_fire;

	// ********************
	// selection
	// ********************
	assign req_idx    = req_pc_i[bp_cfg_pkg::PC_IDX_LSB +: bp_cfg_pkg::CHOICE_IDX_WIDTH];
	assign train_idx  = train_pc_i[bp_cfg_pkg::PC_IDX_LSB +: bp_cfg_pkg::CHOICE_IDX_WIDTH];
	assign req_choice = cht[req_idx];
	assign use_global = (req_choice == bp_types_pkg::weak_global) ||
	                    (req_choice == bp_types_pkg::strong_global);

	// ********************
	// handshake
	// ********************
	// free slot, or the held result leaves this cycle
	assign req_ready_o = !res_valid_o || res_ready_i;
	assign req_fire    = req_valid_i && req_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid_o <= 1'b0;
		end else if (req_fire) begin
			res_valid_o <= 1'b1;
		end else if (res_ready_i) begin
			res_valid_o <= 1'b0;
		end
	end

	// result payload held until drained
	always_ff @(posedge clk) begin
		if (req_fire) begin
			res_taken_o  <= use_global ? global_pred_i : local_pred_i;
			res_local_o  <= local_pred_i;
			res_global_o <= global_pred_i;
			res_ghr_o    <= ghr_i;
		end
	end

	// train only on disagreement and toward whichever side was right
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < bp_cfg_pkg::CHOICE_ENTRIES; i++) begin
				cht[i] <= bp_types_pkg::weak_local;
			end
		end else if (train_valid_i && (train_local_i != train_global_i)) begin
			cht[train_idx] <= bp_types_pkg::choice_update(cht[train_idx],
			                                              train_global_i == train_taken_i);
		end
	end

endmodule

//--- bp_top.sv
`timescale 1ns/100ps

module bp_top (
	input  logic                              clk,
	input  logic                              rst,
	// prediction request
	input  logic                              req_valid_i,
	output logic                              req_ready_o,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   req_pc_i,
	// prediction result
	output logic                              res_valid_o,
	input  logic                              res_ready_i,
	output logic                              res_taken_o,
	output logic                              res_local_o,
	output logic                              res_global_o,
	output logic [bp_cfg_pkg::GHR_WIDTH-1:0]  res_ghr_o,
	// training is never stalled
	input  logic                              train_valid_i,
	input  logic [bp_cfg_pkg::PC_WIDTH-1:0]   train_pc_i,
	input  logic                              train_taken_i,
	input  logic                              train_local_i,
	input  logic                              train_global_i,
	input  logic [bp_cfg_pkg::GHR_WIDTH-1:0]  train_ghr_i
);

	logic                             local_pred;
	logic                             global_pred;
	logic [bp_cfg_pkg::GHR_WIDTH-1:0] ghr;

	// ********************
	// component predictors
	// ********************
	local_predictor u_local (
		.clk           (clk),
		.rst           (rst),
		.req_pc_i      (req_pc_i),
		.train_valid_i (train_valid_i),
		.train_pc_i    (train_pc_i),
		.train_taken_i (train_taken_i),
		.local_pred_o  (local_pred)
	);

	global_predictor u_global (
		.clk           (clk),
		.rst           (rst),
		.req_pc_i      (req_pc_i),
		.train_valid_i (train_valid_i),
		.train_pc_i    (train_pc_i),
		.train_taken_i (train_taken_i),
		.train_ghr_i   (train_ghr_i),
		.global_pred_o (global_pred),
		.ghr_o         (ghr)
	);

	// chooser owns the handshake and result register
	tournament_chooser u_chooser (
		.clk            (clk),
		.rst            (rst),
		.req_valid_i    (req_valid_i),
		.req_ready_o    (req_ready_o),
		.req_pc_i       (req_pc_i),
		.local_pred_i   (local_pred),
		.global_pred_i  (global_pred),
		.ghr_i          (ghr),
		.res_valid_o    (res_valid_o),
		.res_ready_i    (res_ready_i),
		.res_taken_o    (res_taken_o),
		.res_local_o    (res_local_o),
		.res_global_o   (res_global_o),
		.res_ghr_o      (res_ghr_o),
		.train_valid_i  (train_valid_i),
		.train_pc_i     (train_pc_i),
		.train_taken_i  (train_taken_i),
		.train_local_i  (train_local_i),
		.train_global_i (train_global_i)
	);

endmodule

//--- bp_props.sv
`timescale 1ns/100ps

module bp_props (
	input logic                             clk,
	input logic                             rst,
	input logic                             req_valid_i,
	input logic                             req_ready_o,
	input logic                             res_valid_o,
	input logic                             res_ready_i,
	input logic                             res_taken_o,
	input logic                             res_local_o,
	input logic                             res_global_o,
	input logic [bp_cfg_pkg::GHR_WIDTH-1:0] res_ghr_o
);

	// ********************
	// handshake rules
	// ********************
	// result register comes out of reset empty
	reset_empty: assert property (@(posedge clk) rst |=> !res_valid_o)
		else $error("result valid after reset");

	// held result keeps its payload
	hold_stable: assert property (@(posedge clk) disable iff (rst)
		(res_valid_o && !res_ready_i) |=>
		(res_valid_o && $stable({res_taken_o, res_local_o, res_global_o, res_ghr_o})))
		else $error("held result changed");

	// a drained result with no new request empties the register
	empty_ready: assert property (@(posedge clk) disable iff (rst)
		(res_valid_o && res_ready_i && !req_valid_i) |=> (!res_valid_o && req_ready_o))
		else $error("result register not empty and ready after drain");

	// a blocked request must not overwrite the result
	no_accept: assert property (@(posedge clk) disable iff (rst)
		(req_valid_i && !req_ready_o) |=>
		(res_valid_o && $stable({res_taken_o, res_local_o, res_global_o, res_ghr_o})))
		else $error("request accepted while not ready");

endmodule

bind tournament_chooser bp_props u_props (.*);

//--- tb_bp.sv
`timescale 1ns/100ps

module tb_bp;

	logic                             clk;
	logic                             rst;
	logic                             req_valid_i;
	logic                             req_ready_o;
	logic [bp_cfg_pkg::PC_WIDTH-1:0]  req_pc_i;
	logic                             res_valid_o;
	logic                             res_ready_i;
	logic                             res_taken_o;
	logic                             res_local_o;
	logic                             res_global_o;
	logic [bp_cfg_pkg::GHR_WIDTH-1:0] res_ghr_o;
	logic                             train_valid_i;
	logic [bp_cfg_pkg::PC_WIDTH-1:0]  train_pc_i;
	logic                             train_taken_i;
	logic                             train_local_i;
	logic                             train_global_i;
	logic [bp_cfg_pkg::GHR_WIDTH-1:0] train_ghr_i;

	int errors;
	int tests;
	int stall_cycles;
	logic test_bad;

	bp_top uut (.*);

	always #10 clk = ~clk;

	// ********************
	// helpers
	// ********************
	task automatic check_value(input logic [127:0] test, input logic [127:0] field,
	                           input logic [7:0] exp, input logic [7:0] act);
		assert (exp == act) else begin
			$display("ERROR %0s %0s expected %0h actual %0h", test, field, exp, act);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	// every wait gives up after 50 cycles
	task automatic wait_signal(input logic [127:0] test, input bit want_ready);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (!(want_ready ? req_ready_o : res_valid_o) && cnt < 50) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= 50) begin
			$display("timeout in test %0s: DUT never raised %0s", test,
			         want_ready ? "req_ready_o" : "res_valid_o");
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic predict(input logic [127:0] test, input logic [31:0] pc,
	                       input logic [7:0] e_taken, input logic [7:0] e_local,
	                       input logic [7:0] e_global, input logic [7:0] e_ghr);
		logic [10:0] held;
		test_bad = 1'b0;
		tests++;
		wait_signal(test, 1'b1);
		@(posedge clk);
		req_valid_i <= 1'b1;
		req_pc_i    <= pc;
		@(posedge clk);
		req_valid_i <= 1'b0;
		wait_signal(test, 1'b0);
		check_value(test, "taken", e_taken, {7'b0, res_taken_o});
		check_value(test, "local", e_local, {7'b0, res_local_o});
		check_value(test, "global", e_global, {7'b0, res_global_o});
		check_value(test, "ghr", e_ghr, res_ghr_o);
		// under back-pressure the result must sit still and block requests
		held = {res_taken_o, res_local_o, res_global_o, res_ghr_o};
		if (stall_cycles > 0) begin
			// competing request at another pc waits for the drain
			@(posedge clk);
			req_valid_i <= 1'b1;
			req_pc_i    <= pc ^ 32'h24;
		end
		for (int i = 0; i < stall_cycles; i++) begin
			@(negedge clk);
			assert (res_valid_o && !req_ready_o &&
			        held == {res_taken_o, res_local_o, res_global_o, res_ghr_o}) else begin
				$display("test %0s: result changed or request accepted during stall", test);
				errors++;
				test_bad = 1'b1;
			end
		end
		if (stall_cycles > 0) begin
			@(posedge clk);
			req_valid_i <= 1'b0;
			res_ready_i <= 1'b1;
		end
		stall_cycles = 0;
		$display("test %0s: %0s", test, test_bad ? "failed" : "ok");
	endtask

	task automatic train(input logic [31:0] pc, input logic taken, input logic loc,
	                     input logic glob, input logic [7:0] ghr);
		@(posedge clk);
		train_valid_i  <= 1'b1;
		train_pc_i     <= pc;
		train_taken_i  <= taken;
		train_local_i  <= loc;
		train_global_i <= glob;
		train_ghr_i    <= ghr;
		@(posedge clk);
		train_valid_i <= 1'b0;
	endtask

	// ********************
	// main sequence
	// ********************
	initial begin
		int fd;
		int code;
		logic [7:0] kind;
		logic [127:0] name;
		logic [1023:0] line;
		logic [31:0] pc;
		logic [7:0] f_taken;
		logic [7:0] f_local;
		logic [7:0] f_global;
		logic [7:0] f_ghr;
		int n;
		errors = 0;
		tests = 0;
		stall_cycles = 0;
		clk = 1'b0;
		rst <= 1'b1;
		req_valid_i <= 1'b0;
		req_pc_i <= '0;
		res_ready_i <= 1'b1;
		train_valid_i <= 1'b0;
		train_pc_i <= '0;
		train_taken_i <= 1'b0;
		train_local_i <= 1'b0;
		train_global_i <= 1'b0;
		train_ghr_i <= '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen("bp_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file bp_stim.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %s", kind) == 1) begin
				if (kind == "P") begin
					code = $fscanf(fd, " %s %h %h %h %h %h", name, pc, f_taken, f_local,
					               f_global, f_ghr);
					if (code != 6) begin
						$display("stimulus line %0s could not be read", name);
						errors++;
					end else begin
						predict(name, pc, f_taken, f_local, f_global, f_ghr);
					end
				end else if (kind == "T") begin
					code = $fscanf(fd, " %s %h %h %h %h %h", name, pc, f_taken, f_local,
					               f_global, f_ghr);
					if (code != 6) begin
						$display("stimulus line %0s could not be read", name);
						errors++;
					end else begin
						train(pc, f_taken[0], f_local[0], f_global[0], f_ghr);
					end
				end else if (kind == "S") begin
					code = $fscanf(fd, " %s %d", name, n);
					if (code != 2) begin
						$display("stimulus line %0s could not be read", name);
						errors++;
					end else begin
						stall_cycles = n;
						@(posedge clk);
						res_ready_i <= 1'b0;
					end
				end else begin
					// comment line
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
		repeat (2) @(posedge clk);
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- bp_stim.txt
# P name pc taken local global ghr : predict, expect results (hex)
# T name pc taken local global ghr : train, S name cycles : hold res_ready low
# reset state
P reset_a 00000100 0 0 0 00
P reset_b 00000204 0 0 0 00
P reset_c 000003c8 0 0 0 00
# local history saturates, then pattern counter trains
T loc_t1 00000044 1 0 0 00
T loc_t2 00000044 1 0 0 01
T loc_t3 00000044 1 0 0 03
T loc_t4 00000044 1 0 0 07
T loc_t5 00000044 1 0 0 0f
P local_taken 00000044 1 1 0 1f
P local_alias 00000084 1 1 0 1f
# taken then not taken on one branch
T pat_t1 00000010 1 0 0 1f
T pat_t2 00000010 0 0 0 3f
P pattern_ghr 00000010 0 0 0 7e
T gsh_t1 00000010 1 0 0 ff
T gsh_t2 00000010 1 0 0 ff
P gshare_local 00000010 0 0 1 ff
# local wrong, global right
T cho_t1 00000010 1 0 1 ff
T cho_t2 00000010 1 0 1 ff
T lower_t1 00000044 0 0 0 ff
T ghr_t1 00000008 1 0 0 ff
P chooser_global 00000010 1 0 1 ff
# back-pressure on the result
S stall_a 3
P stall_hold 00000020 1 1 0 ff
P after_drain 00000044 0 0 0 ff

//--- build.f
bp_cfg_pkg.sv
bp_types_pkg.sv
local_predictor.sv
global_predictor.sv
tournament_chooser.sv
bp_top.sv
bp_props.sv
tb_bp.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_bp -o tb_bp &&
out="$(./obj_dir/tb_bp)" &&
echo "$out" &&
echo "$out" | grep -q "^Finished with no errors$" &&
echo "run passed" ||
{ echo "$out"; echo "run failed"; exit 1; }
